//--- filelist.f
+incdir+dv
design/mem_stage_pkg.sv
design/mem_stage_ctrl.sv
design/store_align.sv
design/load_writeback.sv
design/mem_stage.sv
dv/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - design/mem_stage_pkg.sv
  - design/mem_stage_ctrl.sv
  - design/store_align.sv
  - design/load_writeback.sv
  - design/mem_stage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mem_stage.sv

//--- dv/mem_stage_model.svh
`ifndef MEM_STAGE_MODEL_SVH
`define MEM_STAGE_MODEL_SVH

logic [63:0] model_mem [logic [31:0]]; // only written doublewords

function automatic bit is_load(mem_op_e op);
  return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD};
endfunction

function automatic bit is_store(mem_op_e op);
  return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
endfunction

function automatic int access_bytes(mem_op_e op);
  case (op)
    OP_LB, OP_LBU, OP_SB: return 1;
    OP_LH, OP_LHU, OP_SH: return 2;
    OP_LW, OP_LWU, OP_SW: return 4;
    OP_LD, OP_SD:         return 8;
    default:              return 0;
  endcase
endfunction

// first byte lane, offset rounded down to the access size
function automatic int lane_base(mem_op_e op, logic [2:0] ofs);
  int n;
  n = access_bytes(op);
  if (n == 0) return 0;
  return (int'(ofs) / n) * n;
endfunction

function automatic logic [7:0] expect_mask(mem_op_e op, logic [2:0] ofs);
  logic [7:0] m;
  int         base;
  m = '0;
  base = lane_base(op, ofs);
  if (is_store(op)) begin
    for (int i = 0; i < access_bytes(op); i++) m[base+i] = 1'b1;
  end
  return m;
endfunction

function automatic logic [63:0] expect_wdata(mem_op_e op, logic [2:0] ofs, logic [63:0] rs2);
  logic [7:0]  m;
  int          base;
  logic [63:0] w;
  m = expect_mask(op, ofs);
  base = lane_base(op, ofs);
  w = '0;
  for (int i = 0; i < 8; i++) begin
    if (m[i]) w[8*i +: 8] = rs2[8*(i-base) +: 8]; // low bytes of rs2 into the lanes
  end
  return w;
endfunction

function automatic logic [63:0] expect_load(mem_op_e op, logic [2:0] ofs, logic [63:0] dw);
  int          n;
  int          base;
  logic [63:0] v;
  bit          sgn;
  v = '0;
  if (!is_load(op)) return v;
  n = access_bytes(op);
  base = lane_base(op, ofs);
  for (int i = 0; i < n; i++) v[8*i +: 8] = dw[8*(base+i) +: 8];
  sgn = op inside {OP_LB, OP_LH, OP_LW};
  if (sgn && v[8*n-1]) v = v | ~((64'd1 << (8*n)) - 64'd1);
  return v;
endfunction

function automatic logic [63:0] mem_read(logic [31:0] addr);
  if (model_mem.exists(addr)) return model_mem[addr];
  return 64'd0; // never written
endfunction

task automatic mem_write(input logic [31:0] addr, input logic [7:0] be, input logic [63:0] wd);
  logic [63:0] w;
  w = mem_read(addr);
  for (int i = 0; i < 8; i++) begin
    if (be[i]) w[8*i +: 8] = wd[8*i +: 8];
  end
  model_mem[addr] = w;
endtask

`endif

//--- dv/tb_mem_stage.sv
module tb_mem_stage;

  import mem_stage_pkg::*;

  `include "mem_stage_model.svh"

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        arst_n;
  logic        in_enable;
  logic        in_flush;
  stage_in_t   stage_in;
  logic        mem_resp_valid;
  logic [63:0] mem_rdata;
  logic        out_ready;
  logic        mem_req_valid;
  logic [31:0] mem_addr;
  mem_req_t    mem_req;
  stage_out_t  stage_out;
  logic        out_valid;
  integer      seed;

  mem_op_e store_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
  mem_op_e load_ops  [7] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD};

  mem_stage #(
    .MEM_ADDR_W (32)
  ) u_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_enable      (in_enable),
    .in_flush       (in_flush),
    .stage_in       (stage_in),
    .mem_resp_valid (mem_resp_valid),
    .mem_rdata      (mem_rdata),
    .out_ready      (out_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_addr       (mem_addr),
    .mem_req        (mem_req),
    .stage_out      (stage_out),
    .out_valid      (out_valid)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [$bits(stage_out_t)-1:0] exp,
                             input logic [$bits(stage_out_t)-1:0] act);
    assert (act === exp) else begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // small address pool so loads hit earlier stores
  task automatic random_op(input mem_op_e op, input logic [2:0] ofs, output stage_in_t s);
    logic [1:0] slot;
    slot = $random(seed);
    s.op                = op;
    s.alu_result[63:32] = $random(seed);
    s.alu_result[31:0]  = 32'h0000_1000 + {slot, ofs};
    s.rs2_value         = {$random(seed), $random(seed)};
    s.pc_target         = {$random(seed), $random(seed)};
    s.rd_regno          = $random(seed);
    s.update_rd         = $random(seed);
    s.branch_taken      = $random(seed);
  endtask

  function automatic stage_out_t expect_out(stage_in_t s, logic [63:0] mdata);
    stage_out_t e;
    e.op           = s.op;
    e.alu_result   = s.alu_result;
    e.rs2_value    = s.rs2_value;
    e.pc_target    = s.pc_target;
    e.rd_regno     = s.rd_regno;
    e.update_rd    = s.update_rd;
    e.branch_taken = s.branch_taken;
    e.mdata        = mdata;
    return e;
  endfunction

  task automatic run_mem_op(input stage_in_t s, input bit stray);
    logic [31:0] addr;
    logic [2:0]  ofs;
    logic [63:0] rd_word;
    int          delay;
    int          cycles;
    ofs  = s.alu_result[2:0];
    addr = {s.alu_result[31:3], 3'b000};
    @(negedge clk);
    stage_in       = s;
    in_enable      = 1'b1;
    mem_resp_valid = stray; // unrequested answer while idle
    mem_rdata      = {$random(seed), $random(seed)};
    #1;
    check_value("req_valid", 1'b1, mem_req_valid);
    check_value("req_addr", addr, mem_addr);
    check_value("req_we", is_store(s.op), mem_req.we);
    check_value("req_be", expect_mask(s.op, ofs), mem_req.be);
    check_value("req_wdata", expect_wdata(s.op, ofs, s.rs2_value), mem_req.wdata.dw);
    check_value("stall", 1'b0, out_ready);
    delay   = 1 + ($unsigned($random(seed)) % 6);
    rd_word = mem_read(addr);
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles == delay) begin
        mem_resp_valid = 1'b1;
        mem_rdata      = rd_word;
      end else begin
        mem_resp_valid = 1'b0;
        mem_rdata      = {$random(seed), $random(seed)}; // junk off the strobe
      end
      #1;
      if (cycles > TIMEOUT) report_timeout("out_ready after a memory access");
      if (!out_ready) check_value("no_extra_req", 1'b0, mem_req_valid);
    end while (!out_ready);
    check_value("ready_at_resp", delay, cycles);
    if (is_store(s.op)) begin
      mem_write(addr, expect_mask(s.op, ofs), expect_wdata(s.op, ofs, s.rs2_value));
    end
    @(negedge clk);
    mem_resp_valid = 1'b0;
    in_enable      = 1'b0;
    #1;
    check_value("out_valid", 1'b1, out_valid);
    check_value("stage_out", expect_out(s, expect_load(s.op, ofs, rd_word)), stage_out);
    @(negedge clk);
    #1;
    check_value("out_valid_pulse", 1'b0, out_valid);
  endtask

  task automatic run_plain_op(input stage_in_t s);
    @(negedge clk);
    stage_in  = s;
    in_enable = 1'b1;
    #1;
    check_value("plain_ready", 1'b1, out_ready);
    check_value("plain_no_req", 1'b0, mem_req_valid);
    @(negedge clk);
    in_enable = 1'b0;
    #1;
    check_value("plain_valid", 1'b1, out_valid);
    check_value("plain_out", expect_out(s, 64'd0), stage_out);
    @(negedge clk);
    #1;
    check_value("plain_pulse", 1'b0, out_valid);
  endtask

  task automatic run_flush(input stage_in_t s);
    int hold;
    hold = 1 + ($unsigned($random(seed)) % 3);
    @(negedge clk);
    stage_in  = s;
    in_enable = 1'b1;
    #1;
    check_value("flush_req", 1'b1, mem_req_valid);
    repeat (hold) begin
      @(negedge clk);
      #1;
      check_value("flush_stall", 1'b0, out_ready);
    end
    @(negedge clk);
    in_flush = 1'b1;
    #1;
    check_value("flush_ready", 1'b1, out_ready);
    @(negedge clk);
    #1;
    check_value("flush_no_req", 1'b0, mem_req_valid); // idle again with the load still offered
    check_value("flush_idle_ready", 1'b1, out_ready);
    check_value("flush_clear", '0, stage_out);
    check_value("flush_valid", 1'b0, out_valid);
    @(negedge clk);
    in_flush  = 1'b0;
    in_enable = 1'b0;
    #1;
    check_value("flush_held", '0, stage_out);
    check_value("flush_no_valid", 1'b0, out_valid);
  endtask

  initial begin
    stage_in_t  s;
    logic [3:0] code;
    logic [2:0] o;
    seed           = 32'h2df8;
    clk            = 1'b0;
    arst_n         = 1'b0;
    in_enable      = 1'b0;
    in_flush       = 1'b0;
    stage_in       = '0;
    mem_resp_valid = 1'b0;
    mem_rdata      = '0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    #1;
    check_value("rst_out_valid", 1'b0, out_valid);
    check_value("rst_req_valid", 1'b0, mem_req_valid);
    check_value("rst_stage_out", '0, stage_out);
    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 8; j++) begin
        random_op(store_ops[k], j[2:0], s);
        run_mem_op(s, 1'b0);
      end
    end
    for (int k = 0; k < 7; k++) begin
      for (int j = 0; j < 8; j++) begin
        random_op(load_ops[k], j[2:0], s);
        run_mem_op(s, 1'b0);
      end
    end
    for (int n = 0; n < 300; n++) begin
      code = $random(seed);
      o    = $random(seed);
      random_op(mem_op_e'(code), o, s);
      if (is_load(s.op) || is_store(s.op)) run_mem_op(s, 1'b0);
      else run_plain_op(s);
      if (n % 75 == 74) begin
        random_op(load_ops[n % 7], o, s);
        run_flush(s);
        random_op(load_ops[(n + 3) % 7], o, s);
        run_mem_op(s, 1'b1); // late answer to the abandoned load
      end
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- design/mem_stage.sv
module mem_stage #(
  parameter int MEM_ADDR_W = 32
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                in_enable,
  input  logic                                in_flush,
  input  mem_stage_pkg::stage_in_t            stage_in,
  input  logic                                mem_resp_valid,
  input  logic [mem_stage_pkg::XLEN-1:0]      mem_rdata,
  output logic                                out_ready,
  output logic                                mem_req_valid,
  output logic [MEM_ADDR_W-1:0]               mem_addr,
  output mem_stage_pkg::mem_req_t             mem_req,
  output mem_stage_pkg::stage_out_t           stage_out,
  output logic                                out_valid
);

  import mem_stage_pkg::*;

  logic                 cap_en;
  logic                 req_we;
  logic [NUM_LANES-1:0] req_be;
  mem_word_u            req_wdata;
  mem_word_u            rdata_word;

  assign rdata_word.dw = mem_rdata;

  // request payload from control and store lanes
  assign mem_req.we    = req_we;
  assign mem_req.be    = req_be;
  assign mem_req.wdata = req_wdata;

  mem_stage_ctrl #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_enable      (in_enable),
    .in_flush       (in_flush),
    .stage_in       (stage_in),
    .mem_resp_valid (mem_resp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_addr       (mem_addr),
    .mem_we         (req_we),
    .out_ready      (out_ready),
    .cap_en         (cap_en)
  );

  store_align u_store_align (
    .stage_in (stage_in),
    .be       (req_be),
    .wdata    (req_wdata)
  );

  load_writeback u_load_wb (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_flush  (in_flush),
    .cap_en    (cap_en),
    .stage_in  (stage_in),
    .mem_rdata (rdata_word),
    .stage_out (stage_out),
    .out_valid (out_valid)
  );

endmodule

//--- design/load_writeback.sv
module load_writeback (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_flush,
  input  logic                      cap_en,
  input  mem_stage_pkg::stage_in_t  stage_in,
  input  mem_stage_pkg::mem_word_u  mem_rdata,
  output mem_stage_pkg::stage_out_t stage_out,
  output logic                      out_valid
);

  import mem_stage_pkg::*;

  logic [LANE_IDX_W-1:0] ofs;
  logic [7:0]            byte_lane;
  logic [15:0]           half_lane;
  logic [31:0]           word_lane;
  logic [XLEN-1:0]       mdata;
  stage_out_t            cap_value;

  assign ofs = stage_in.alu_result[LANE_IDX_W-1:0];

  // lane pick, low offset bits ignored per size
  assign byte_lane = mem_rdata.b[ofs];
  assign half_lane = mem_rdata.h[ofs[2:1]];
  assign word_lane = mem_rdata.w[ofs[2]];

  always_comb begin
    case (stage_in.op)
      OP_LB: begin
        mdata = {{(XLEN-8){byte_lane[7]}}, byte_lane};
      end
      OP_LBU: begin
        mdata = {{(XLEN-8){1'b0}}, byte_lane};
      end
      OP_LH: begin
        mdata = {{(XLEN-16){half_lane[15]}}, half_lane};
      end
      OP_LHU: begin
        mdata = {{(XLEN-16){1'b0}}, half_lane};
      end
      OP_LW: begin
        mdata = {{(XLEN-32){word_lane[31]}}, word_lane};
      end
      OP_LWU: begin
        mdata = {{(XLEN-32){1'b0}}, word_lane};
      end
      OP_LD: begin
        mdata = mem_rdata.dw;
      end
      default: begin
        mdata = '0; // stores and non-memory ops
      end
    endcase
  end

  always_comb begin
    cap_value.op           = stage_in.op;
    cap_value.alu_result   = stage_in.alu_result;
    cap_value.rs2_value    = stage_in.rs2_value;
    cap_value.pc_target    = stage_in.pc_target;
    cap_value.rd_regno     = stage_in.rd_regno;
    cap_value.update_rd    = stage_in.update_rd;
    cap_value.branch_taken = stage_in.branch_taken;
    cap_value.mdata        = mdata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_out <= '0;
      out_valid <= 1'b0;
    end else if (in_flush) begin
      stage_out <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= cap_en; // one cycle per capture
      if (cap_en) begin
        stage_out <= cap_value;
      end
    end
  end

endmodule

//--- design/store_align.sv
module store_align (
  input  mem_stage_pkg::stage_in_t                 stage_in,
  output logic [mem_stage_pkg::NUM_LANES-1:0]      be,
  output mem_stage_pkg::mem_word_u                 wdata
);

  import mem_stage_pkg::*;

  logic [LANE_IDX_W-1:0] ofs;

  assign ofs = stage_in.alu_result[LANE_IDX_W-1:0];

  // misaligned offsets drop the bits below the access size
  always_comb begin
    be    = '0;
    wdata = '0;
    case (stage_in.op)
      OP_SB: begin
        wdata.b[ofs] = stage_in.rs2_value[7:0];
        be[ofs]      = 1'b1;
      end
      OP_SH: begin
        wdata.h[ofs[2:1]] = stage_in.rs2_value[15:0];
        be                = 8'b0000_0011 << {ofs[2:1], 1'b0};
      end
      OP_SW: begin
        wdata.w[ofs[2]] = stage_in.rs2_value[31:0];
        be              = 8'b0000_1111 << {ofs[2], 2'b00};
      end
      OP_SD: begin
        wdata.dw = stage_in.rs2_value;
        be       = '1; // full doubleword
      end
      default: begin
        be    = '0;
        wdata = '0;
      end
    endcase
  end

endmodule

//--- design/mem_stage_ctrl.sv
module mem_stage_ctrl #(
  parameter int MEM_ADDR_W = 32
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     in_enable,
  input  logic                     in_flush,
  input  mem_stage_pkg::stage_in_t stage_in,
  input  logic                     mem_resp_valid,
  output logic                     mem_req_valid,
  output logic [MEM_ADDR_W-1:0]    mem_addr,
  output logic                     mem_we,
  output logic                     out_ready,
  output logic                     cap_en
);

  import mem_stage_pkg::*;

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_WAIT = 1'b1; // access outstanding

  logic state_q;
  logic state_d;
  logic op_load;
  logic op_store;
  logic mem_access;
  logic resp_done;

  // classify the operation
  always_comb begin
    op_load  = 1'b0;
    op_store = 1'b0;
    case (stage_in.op)
      OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD: begin
        op_load = 1'b1;
      end
      OP_SB, OP_SH, OP_SW, OP_SD: begin
        op_store = 1'b1;
      end
      default: begin
        op_load  = 1'b0;
        op_store = 1'b0;
      end
    endcase
  end

  assign mem_access = in_enable & (op_load | op_store);
  assign resp_done  = (state_q == ST_WAIT) & mem_resp_valid; // stray responses dropped in idle

  // one pulse per access, only from idle
  assign mem_req_valid = (state_q == ST_IDLE) & mem_access & ~in_flush;

  assign mem_addr = {stage_in.alu_result[MEM_ADDR_W-1:LANE_IDX_W], {LANE_IDX_W{1'b0}}};
  assign mem_we   = op_store;

  // memory ops stall until the response, all else passes
  assign out_ready = in_flush | ~mem_access | resp_done;
  assign cap_en    = in_enable & out_ready & ~in_flush;

  always_comb begin
    state_d = state_q;
    if (in_flush) begin
      state_d = ST_IDLE; // abandon any outstanding access
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (mem_req_valid) begin
            state_d = ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (mem_resp_valid) begin
            state_d = ST_IDLE;
          end
        end
        default: begin
          state_d = ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- design/mem_stage_pkg.sv
package mem_stage_pkg;

  localparam int XLEN       = 64;
  localparam int NUM_LANES  = 8;
  localparam int LANE_IDX_W = 3; // byte offset inside a doubleword

  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LBU  = 4'd2,
    OP_LH   = 4'd3,
    OP_LHU  = 4'd4,
    OP_LW   = 4'd5,
    OP_LWU  = 4'd6,
    OP_LD   = 4'd7,
    OP_SB   = 4'd8,
    OP_SH   = 4'd9,
    OP_SW   = 4'd10,
    OP_SD   = 4'd11
  } mem_op_e;

  // one doubleword seen at every access size
  typedef union packed {
    logic [XLEN-1:0]                dw;
    logic [1:0][XLEN/2-1:0]         w;
    logic [3:0][XLEN/4-1:0]         h;
    logic [NUM_LANES-1:0][7:0]      b;
  } mem_word_u;

  typedef struct packed {
    mem_op_e         op;
    logic [XLEN-1:0] alu_result;   // address for loads and stores
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] pc_target;
    logic [4:0]      rd_regno;
    logic            update_rd;
    logic            branch_taken;
  } stage_in_t;

  typedef struct packed {
    mem_op_e         op;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] pc_target;
    logic [4:0]      rd_regno;
    logic            update_rd;
    logic            branch_taken;
    logic [XLEN-1:0] mdata;        // load result
  } stage_out_t;

  // address is sized per instance and travels beside this
  typedef struct packed {
    logic                 we;
    logic [NUM_LANES-1:0] be;
    mem_word_u            wdata;
  } mem_req_t;

endpackage
